//--- dispatch_pkg.sv
// Dispatch stage shared definitions
// Default sizes, decode encodings and the packed bundles passed
// between the fetch queue, the dispatch stage and the ROB/RS side

package dispatch_pkg;

    // ==================================================
    // Default sizes
    // ==================================================
    localparam int DP_NUM_DEF       = 2;
    localparam int ARCH_REG_NUM_DEF = 32;
    localparam int PHY_REG_NUM_DEF  = 64;

    typedef logic [4:0] arch_idx_t;
    typedef logic [5:0] tag_t;
    // Group count, 0 up to the dispatch width
    typedef logic [1:0] cnt_t;

    // x0 index, also used as the "no destination" tag
    localparam arch_idx_t ZERO_REG = 5'd0;

    // ==================================================
    // Decode encodings
    // ==================================================
    typedef enum logic [2:0] {
        FU_ALU, FU_MULT, FU_LOAD, FU_STORE,
        FU_BRANCH, FU_JUMP, FU_HALT, FU_ILLEGAL
    } fu_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    // First operand source
    typedef enum logic [1:0] {
        OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO
    } opa_sel_e;

    // Second operand source, register or one of the immediate formats
    typedef enum logic [2:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
        OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
    } opb_sel_e;

    // Dispatch control FSM
    typedef enum logic [1:0] {
        IDLE, OFFER, DONE
    } ctrl_state_e;

    // ==================================================
    // Bundles
    // ==================================================
    // One decoded slot, unused indices read as x0
    typedef struct packed {
        fu_class_e fu_class;
        alu_func_e alu_func;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        arch_idx_t rd;
        arch_idx_t rs1;
        arch_idx_t rs2;
    } dec_slot_t;

    // Group offered by the fetch queue
    typedef struct packed {
        logic [DP_NUM_DEF-1:0][31:0] pc;
        logic [DP_NUM_DEF-1:0][31:0] inst;
        cnt_t                        fiq_avail;
    } fiq_group_t;

    // Free entries downstream plus the next free tags in order
    typedef struct packed {
        cnt_t                  rob_avail;
        cnt_t                  rs_avail;
        cnt_t                  fl_avail;
        tag_t [DP_NUM_DEF-1:0] fl_tag;
    } avail_t;

    // One dispatched slot toward the ROB and RS
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        dec_slot_t   dec;
        tag_t        tag;
        tag_t        tag1;
        tag_t        tag2;
        tag_t        tag_old;
    } dp_slot_t;

endpackage

//--- inst_decoder.sv
// RV32IM decoder for one dispatch slot
// Gives execution class, ALU function, operand selects and the
// register indices the format actually reads or writes
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]             inst_i,
    output dispatch_pkg::dec_slot_t dec_o
);
    import dispatch_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_used;
    logic       rs1_used;
    logic       rs2_used;
    logic       bad;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // funct3 map shared by OP and OP-IMM
    function automatic alu_func_e base_func(input logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ==================================================
    // Opcode decode
    // ==================================================
    always_comb begin
        // Defaults behave as a plain ADD with no registers
        dec_o.fu_class = FU_ALU;
        dec_o.alu_func = ALU_ADD;
        dec_o.opa_sel  = OPA_IS_RS1;
        dec_o.opb_sel  = OPB_IS_RS2;
        rd_used        = 1'b0;
        rs1_used       = 1'b0;
        rs2_used       = 1'b0;
        bad            = 1'b0;
        case (opcode)
            7'b0110111: begin
                // LUI
                rd_used        = 1'b1;
                dec_o.opa_sel  = OPA_IS_ZERO;
                dec_o.opb_sel  = OPB_IS_U_IMM;
            end
            7'b0010111: begin
                // AUIPC
                rd_used        = 1'b1;
                dec_o.opa_sel  = OPA_IS_PC;
                dec_o.opb_sel  = OPB_IS_U_IMM;
            end
            7'b1101111: begin
                // JAL
                rd_used        = 1'b1;
                dec_o.fu_class = FU_JUMP;
                dec_o.opa_sel  = OPA_IS_PC;
                dec_o.opb_sel  = OPB_IS_J_IMM;
            end
            7'b1100111: begin
                // JALR
                rd_used        = 1'b1;
                rs1_used       = 1'b1;
                dec_o.fu_class = FU_JUMP;
                dec_o.opb_sel  = OPB_IS_I_IMM;
                bad            = (funct3 != 3'b000);
            end
            7'b1100011: begin
                // Branches, funct3 010 and 011 unassigned
                rs1_used       = 1'b1;
                rs2_used       = 1'b1;
                dec_o.fu_class = FU_BRANCH;
                dec_o.opa_sel  = OPA_IS_PC;
                dec_o.opb_sel  = OPB_IS_B_IMM;
                bad            = (funct3[2:1] == 2'b01);
            end
            7'b0000011: begin
                // LB LH LW LBU LHU
                rd_used        = 1'b1;
                rs1_used       = 1'b1;
                dec_o.fu_class = FU_LOAD;
                dec_o.opb_sel  = OPB_IS_I_IMM;
                bad            = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            7'b0100011: begin
                // SB SH SW
                rs1_used       = 1'b1;
                rs2_used       = 1'b1;
                dec_o.fu_class = FU_STORE;
                dec_o.opb_sel  = OPB_IS_S_IMM;
                bad            = funct3[2] || (funct3 == 3'b011);
            end
            7'b0010011: begin
                // Immediate ALU ops, shifts check funct7
                rd_used        = 1'b1;
                rs1_used       = 1'b1;
                dec_o.opb_sel  = OPB_IS_I_IMM;
                dec_o.alu_func = base_func(funct3);
                if (funct3 == 3'b001 && funct7 != 7'b0000000) bad = 1'b1;
                if (funct3 == 3'b101) begin
                    if (funct7 == 7'b0100000) dec_o.alu_func = ALU_SRA;
                    else if (funct7 != 7'b0000000) bad = 1'b1;
                end
            end
            7'b0110011: begin
                // Register ALU ops and the M multiplies
                rd_used  = 1'b1;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                case (funct7)
                    7'b0000000: dec_o.alu_func = base_func(funct3);
                    7'b0100000: begin
                        if (funct3 == 3'b000) dec_o.alu_func = ALU_SUB;
                        else if (funct3 == 3'b101) dec_o.alu_func = ALU_SRA;
                        else bad = 1'b1;
                    end
                    7'b0000001: begin
                        // Divide and remainder not supported
                        dec_o.fu_class = FU_MULT;
                        case (funct3)
                            3'b000:  dec_o.alu_func = ALU_MUL;
                            3'b001:  dec_o.alu_func = ALU_MULH;
                            3'b010:  dec_o.alu_func = ALU_MULHSU;
                            3'b011:  dec_o.alu_func = ALU_MULHU;
                            default: bad = 1'b1;
                        endcase
                    end
                    default: bad = 1'b1;
                endcase
            end
            7'b1110011: begin
                // SYSTEM space, only WFI accepted
                if (inst_i == 32'h1050_0073) dec_o.fu_class = FU_HALT;
                else bad = 1'b1;
            end
            default: bad = 1'b1;
        endcase

        // Illegal words carry no registers and default selects
        if (bad) begin
            dec_o.fu_class = FU_ILLEGAL;
            dec_o.alu_func = ALU_ADD;
            dec_o.opa_sel  = OPA_IS_RS1;
            dec_o.opb_sel  = OPB_IS_RS2;
            rd_used        = 1'b0;
            rs1_used       = 1'b0;
            rs2_used       = 1'b0;
        end

        dec_o.rd  = rd_used  ? inst_i[11:7]  : ZERO_REG;
        dec_o.rs1 = rs1_used ? inst_i[19:15] : ZERO_REG;
        dec_o.rs2 = rs2_used ? inst_i[24:20] : ZERO_REG;
    end

endmodule

//--- resource_check.sv
// Dispatch resource check
// Picks the group size from fetch, ROB, RS and free-list availability,
// cuts it at the first illegal slot and hands out free tags in order
`timescale 1ns/1ps

module resource_check #(
    parameter int DP_NUM = dispatch_pkg::DP_NUM_DEF
) (
    input  dispatch_pkg::dec_slot_t [DP_NUM-1:0] dec_i,
    input  dispatch_pkg::cnt_t                   fiq_avail_i,
    input  dispatch_pkg::cnt_t                   rob_avail_i,
    input  dispatch_pkg::cnt_t                   rs_avail_i,
    input  dispatch_pkg::cnt_t                   fl_avail_i,
    input  dispatch_pkg::tag_t [DP_NUM-1:0]      fl_tag_i,
    output dispatch_pkg::cnt_t                   dp_count_o,
    output dispatch_pkg::cnt_t                   fl_used_o,
    output dispatch_pkg::tag_t [DP_NUM-1:0]      slot_tag_o
);
    import dispatch_pkg::*;

    cnt_t min_front;
    cnt_t min_back;
    cnt_t limit;
    logic stop;
    cnt_t fl_idx;

    // ==================================================
    // Group size
    // ==================================================
    // Pairwise minimum of the four counts
    always_comb begin
        min_front = (rob_avail_i < fiq_avail_i) ? rob_avail_i : fiq_avail_i;
        min_back  = (fl_avail_i < rs_avail_i) ? fl_avail_i : rs_avail_i;
        limit     = (min_front < min_back) ? min_front : min_back;
    end

    // Count legal slots up to the limit, first illegal one ends the group
    always_comb begin
        dp_count_o = '0;
        stop       = 1'b0;
        for (int i = 0; i < DP_NUM; i++) begin
            if (i >= limit || dec_i[i].fu_class == FU_ILLEGAL) stop = 1'b1;
            if (!stop) dp_count_o = dp_count_o + 1'b1;
        end
    end

    // ==================================================
    // Free tag routing
    // ==================================================
    // Writers below the count take tags in order, others get tag 0
    always_comb begin
        fl_idx = '0;
        for (int i = 0; i < DP_NUM; i++) begin
            slot_tag_o[i] = '0;
            if (i < dp_count_o && dec_i[i].rd != ZERO_REG) begin
                slot_tag_o[i] = fl_tag_i[fl_idx];
                fl_idx        = fl_idx + 1'b1;
            end
        end
        fl_used_o = fl_idx;
    end

endmodule

//--- rename_map.sv
// Register map table
// Architectural to physical tag map with bypass from older slots
// of the same group, updated once per dispatched group
`timescale 1ns/1ps

module rename_map #(
    parameter int DP_NUM       = dispatch_pkg::DP_NUM_DEF,
    parameter int ARCH_REG_NUM = dispatch_pkg::ARCH_REG_NUM_DEF,
    parameter int PHY_REG_NUM  = dispatch_pkg::PHY_REG_NUM_DEF
) (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  dispatch_pkg::dec_slot_t [DP_NUM-1:0] dec_i,
    input  dispatch_pkg::tag_t [DP_NUM-1:0]      slot_tag_i,
    input  dispatch_pkg::cnt_t                   dp_count_i,
    input  logic                                 commit_i,
    output dispatch_pkg::tag_t [DP_NUM-1:0]      tag1_o,
    output dispatch_pkg::tag_t [DP_NUM-1:0]      tag2_o,
    output dispatch_pkg::tag_t [DP_NUM-1:0]      tag_old_o
);
    import dispatch_pkg::*;

    localparam int TAG_W = $clog2(PHY_REG_NUM);

    // One tag per architectural register
    logic [TAG_W-1:0] map_q [ARCH_REG_NUM];

    // ==================================================
    // Lookup with intra-group bypass
    // ==================================================
    always_comb begin
        for (int s = 0; s < DP_NUM; s++) begin
            tag1_o[s]    = map_q[dec_i[s].rs1];
            tag2_o[s]    = map_q[dec_i[s].rs2];
            tag_old_o[s] = map_q[dec_i[s].rd];
            // Ascending scan, so the youngest older writer wins
            for (int o = 0; o < s; o++) begin
                if (o < dp_count_i && dec_i[o].rd != ZERO_REG) begin
                    if (dec_i[o].rd == dec_i[s].rs1) tag1_o[s] = slot_tag_i[o];
                    if (dec_i[o].rd == dec_i[s].rs2) tag2_o[s] = slot_tag_i[o];
                    if (dec_i[o].rd == dec_i[s].rd) tag_old_o[s] = slot_tag_i[o];
                end
            end
        end
    end

    // ==================================================
    // Table update
    // ==================================================
    // Identity after reset, x0 is never remapped
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < ARCH_REG_NUM; i++) begin
                map_q[i] <= TAG_W'(i);
            end
        end else if (commit_i) begin
            // Later slots overwrite earlier ones to the same rd
            for (int s = 0; s < DP_NUM; s++) begin
                if (s < dp_count_i && dec_i[s].rd != ZERO_REG) begin
                    map_q[dec_i[s].rd] <= slot_tag_i[s];
                end
            end
        end
    end

endmodule

//--- dispatch_ctrl.sv
// Dispatch control FSM
// Runs the four-phase handshakes toward the fetch queue and the
// ROB/RS side and strobes the map table write on acceptance
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic fiq_req_i,
    input  logic dp_ack_i,
    output logic fiq_ack_o,
    output logic dp_req_o,
    output logic commit_o
);
    import dispatch_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            // Upstream group stable, offer it downstream
            IDLE:    if (fiq_req_i) state_d = OFFER;
            // Hold the offer until accepted
            OFFER:   if (dp_ack_i) state_d = DONE;
            // Wait for both partners to release
            DONE:    if (!fiq_req_i && !dp_ack_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================
    // Outputs
    // ==================================================
    // Handshake lines decoded from state, so both are registered
    assign dp_req_o  = (state_q == OFFER);
    assign fiq_ack_o = (state_q == DONE);

    // Single cycle, map written on the edge that leaves OFFER
    assign commit_o  = (state_q == OFFER) && dp_ack_i;

endmodule

//--- dispatch_stage.sv
// Dispatch stage top level
// Decodes, sizes and renames a fetch group of up to DP_NUM
// instructions and offers the dispatch bundle to the ROB/RS side
`timescale 1ns/1ps

module dispatch_stage #(
    parameter int DP_NUM       = dispatch_pkg::DP_NUM_DEF,
    parameter int ARCH_REG_NUM = dispatch_pkg::ARCH_REG_NUM_DEF,
    parameter int PHY_REG_NUM  = dispatch_pkg::PHY_REG_NUM_DEF
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                fiq_req_i,
    input  dispatch_pkg::fiq_group_t            fiq_group_i,
    input  dispatch_pkg::avail_t                avail_i,
    output logic                                fiq_ack_o,
    output dispatch_pkg::cnt_t                  fiq_taken_o,
    output logic                                dp_req_o,
    input  logic                                dp_ack_i,
    output dispatch_pkg::dp_slot_t [DP_NUM-1:0] dp_bundle_o,
    output dispatch_pkg::cnt_t                  dp_count_o,
    output dispatch_pkg::cnt_t                  fl_used_o
);
    import dispatch_pkg::*;

    dec_slot_t [DP_NUM-1:0] dec;
    tag_t      [DP_NUM-1:0] slot_tag;
    tag_t      [DP_NUM-1:0] tag1;
    tag_t      [DP_NUM-1:0] tag2;
    tag_t      [DP_NUM-1:0] tag_old;
    logic                   commit;

    // ==================================================
    // Datapath
    // ==================================================
    // One decoder per slot
    genvar gi;
    generate
        for (gi = 0; gi < DP_NUM; gi++) begin : g_dec
            inst_decoder u_dec (
                .inst_i (fiq_group_i.inst[gi]),
                .dec_o  (dec[gi])
            );
        end
    endgenerate

    resource_check #(
        .DP_NUM (DP_NUM)
    ) u_res (
        .dec_i       (dec),
        .fiq_avail_i (fiq_group_i.fiq_avail),
        .rob_avail_i (avail_i.rob_avail),
        .rs_avail_i  (avail_i.rs_avail),
        .fl_avail_i  (avail_i.fl_avail),
        .fl_tag_i    (avail_i.fl_tag),
        .dp_count_o  (dp_count_o),
        .fl_used_o   (fl_used_o),
        .slot_tag_o  (slot_tag)
    );

    rename_map #(
        .DP_NUM       (DP_NUM),
        .ARCH_REG_NUM (ARCH_REG_NUM),
        .PHY_REG_NUM  (PHY_REG_NUM)
    ) u_map (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .dec_i      (dec),
        .slot_tag_i (slot_tag),
        .dp_count_i (dp_count_o),
        .commit_i   (commit),
        .tag1_o     (tag1),
        .tag2_o     (tag2),
        .tag_old_o  (tag_old)
    );

    // ==================================================
    // Control
    // ==================================================
    dispatch_ctrl u_ctrl (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .fiq_req_i (fiq_req_i),
        .dp_ack_i  (dp_ack_i),
        .fiq_ack_o (fiq_ack_o),
        .dp_req_o  (dp_req_o),
        .commit_o  (commit)
    );

    // Fetch queue pops exactly what was dispatched
    assign fiq_taken_o = dp_count_o;

    // Bundle assembly, stable while the upstream group is held
    always_comb begin
        for (int i = 0; i < DP_NUM; i++) begin
            dp_bundle_o[i].pc      = fiq_group_i.pc[i];
            dp_bundle_o[i].inst    = fiq_group_i.inst[i];
            dp_bundle_o[i].dec     = dec[i];
            dp_bundle_o[i].tag     = slot_tag[i];
            dp_bundle_o[i].tag1    = tag1[i];
            dp_bundle_o[i].tag2    = tag2[i];
            dp_bundle_o[i].tag_old = tag_old[i];
        end
    end

endmodule

//--- dispatch_tb_model.svh
// Reference model for the dispatch stage testbench
// Map table, group size and free-tag routing worked out from the
// RV32 register formats and the dispatch rules
`ifndef DISPATCH_TB_MODEL_SVH
`define DISPATCH_TB_MODEL_SVH

// ==================================================
// Model state
// ==================================================
logic [5:0] model_map [32];
logic [2:0] exp_cls   [DP_NUM_DEF];
logic [3:0] exp_func  [DP_NUM_DEF];
logic [1:0] exp_opa   [DP_NUM_DEF];
logic [2:0] exp_opb   [DP_NUM_DEF];
logic [4:0] exp_rd    [DP_NUM_DEF];
logic [4:0] exp_rs1   [DP_NUM_DEF];
logic [4:0] exp_rs2   [DP_NUM_DEF];
logic [5:0] free_tag  [DP_NUM_DEF];
logic [5:0] exp_tag   [DP_NUM_DEF];
logic [5:0] exp_tag1  [DP_NUM_DEF];
logic [5:0] exp_tag2  [DP_NUM_DEF];
logic [5:0] exp_old   [DP_NUM_DEF];
int         exp_count;
int         exp_used;

// Identity map out of reset
task automatic reset_map_model;
    for (int i = 0; i < 32; i++) begin
        model_map[i] = i[5:0];
    end
endtask

// Register fields each format carries with x0 for unused ones
task automatic decode_regs(input int s, input logic [31:0] inst);
    logic [6:0] op;
    logic       rd_on;
    logic       rs1_on;
    logic       rs2_on;
    op     = inst[6:0];
    // Stores, branches, WFI and illegal words write nothing
    rd_on  = exp_cls[s] != FU_STORE && exp_cls[s] != FU_BRANCH &&
             exp_cls[s] != FU_HALT && exp_cls[s] != FU_ILLEGAL;
    // U and J formats have no rs1
    rs1_on = exp_cls[s] != FU_HALT && exp_cls[s] != FU_ILLEGAL &&
             op != 7'h37 && op != 7'h17 && op != 7'h6f;
    // S, B and R formats
    rs2_on = exp_cls[s] == FU_STORE || exp_cls[s] == FU_BRANCH ||
             (exp_cls[s] != FU_ILLEGAL && op == 7'h33);
    exp_rd[s]  = rd_on  ? inst[11:7]  : 5'd0;
    exp_rs1[s] = rs1_on ? inst[19:15] : 5'd0;
    exp_rs2[s] = rs2_on ? inst[24:20] : 5'd0;

    // Operand sources by format, register pair when nothing else applies
    exp_opa[s] = OPA_IS_RS1;
    exp_opb[s] = OPB_IS_RS2;
    if (op == 7'h37) exp_opa[s] = OPA_IS_ZERO;
    // AUIPC, JAL and branch targets are PC relative
    if (op == 7'h17 || op == 7'h6f || op == 7'h63) exp_opa[s] = OPA_IS_PC;
    if (op == 7'h37 || op == 7'h17) exp_opb[s] = OPB_IS_U_IMM;
    if (op == 7'h6f) exp_opb[s] = OPB_IS_J_IMM;
    if (op == 7'h63) exp_opb[s] = OPB_IS_B_IMM;
    if (op == 7'h23) exp_opb[s] = OPB_IS_S_IMM;
    if (op == 7'h67 || op == 7'h03 || op == 7'h13) exp_opb[s] = OPB_IS_I_IMM;
endtask

// Smallest availability cut at the first illegal word
task automatic size_group(input int fiq, input int rob, input int rs, input int fl);
    int lim;
    lim = fiq;
    if (rob < lim) lim = rob;
    if (rs < lim) lim = rs;
    if (fl < lim) lim = fl;
    exp_count = 0;
    while (exp_count < lim && exp_cls[exp_count] != FU_ILLEGAL) begin
        exp_count++;
    end
endtask

// Tags in free-list order and sources through older writers of the group
task automatic rename_group;
    int nxt;
    nxt = 0;
    for (int s = 0; s < DP_NUM_DEF; s++) begin
        exp_tag[s] = 6'd0;
        if (s < exp_count && exp_rd[s] != 5'd0) begin
            exp_tag[s] = free_tag[nxt];
            nxt++;
        end
        exp_tag1[s] = model_map[exp_rs1[s]];
        exp_tag2[s] = model_map[exp_rs2[s]];
        exp_old[s]  = model_map[exp_rd[s]];
        // Later older writer overrides an earlier one
        for (int o = 0; o < s; o++) begin
            if (o < exp_count && exp_rd[o] != 5'd0) begin
                if (exp_rd[o] == exp_rs1[s]) exp_tag1[s] = exp_tag[o];
                if (exp_rd[o] == exp_rs2[s]) exp_tag2[s] = exp_tag[o];
                if (exp_rd[o] == exp_rd[s]) exp_old[s] = exp_tag[o];
            end
        end
    end
    exp_used = nxt;
endtask

// Record the group's new mappings
task automatic commit_group;
    for (int s = 0; s < DP_NUM_DEF; s++) begin
        if (s < exp_count && exp_rd[s] != 5'd0) begin
            model_map[exp_rd[s]] = exp_tag[s];
        end
    end
endtask

`endif

//--- dispatch_stage_tb.sv
// Testbench for the dispatch stage
// Replays fetch groups from the data file through both four-phase
// handshakes and checks decode, group size and renaming
`timescale 1ns/1ps

module dispatch_stage_tb;
    import dispatch_pkg::*;

    localparam int NS          = DP_NUM_DEF;
    localparam int NUM_GROUPS  = 24;
    localparam int FIELDS      = 7 * NS;
    localparam int CYCLE_LIMIT = NUM_GROUPS * 12 + 20;
    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DLY   = 10;

    logic              clk_i;
    logic              arst_n_i;
    logic              fiq_req_i;
    fiq_group_t        fiq_group_i;
    avail_t            avail_i;
    logic              fiq_ack_o;
    cnt_t              fiq_taken_o;
    logic              dp_req_o;
    logic              dp_ack_i;
    dp_slot_t [NS-1:0] dp_bundle_o;
    cnt_t              dp_count_o;
    cnt_t              fl_used_o;

    // One row of FIELDS words per group
    logic [31:0]       tdata [NUM_GROUPS*FIELDS];
    dp_slot_t [NS-1:0] held_bundle;
    integer            seed;
    int                cycle_cnt;
    int                checks;
    int                errors;
    int                grp_err;

    `include "dispatch_tb_model.svh"

    dispatch_stage #(
        .DP_NUM       (DP_NUM_DEF),
        .ARCH_REG_NUM (ARCH_REG_NUM_DEF),
        .PHY_REG_NUM  (PHY_REG_NUM_DEF)
    ) uut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fiq_req_i   (fiq_req_i),
        .fiq_group_i (fiq_group_i),
        .avail_i     (avail_i),
        .fiq_ack_o   (fiq_ack_o),
        .fiq_taken_o (fiq_taken_o),
        .dp_req_o    (dp_req_o),
        .dp_ack_i    (dp_ack_i),
        .dp_bundle_o (dp_bundle_o),
        .dp_count_o  (dp_count_o),
        .fl_used_o   (fl_used_o)
    );

    initial clk_i = 1'b0;
    always #CLK_HALF clk_i = ~clk_i;

    // ==================================================
    // Helpers
    // ==================================================
    task automatic compare_field(input int g, input string what,
                                 input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            grp_err++;
            $display("Mismatch at %0d ns: group %0d %s got %0h expected %0h",
                     $time, g, what, got, exp);
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic next_drive_point;
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic load_group(input int g);
        int b;
        b = g * FIELDS;
        for (int s = 0; s < NS; s++) begin
            fiq_group_i.pc[s]   = tdata[b + s];
            fiq_group_i.inst[s] = tdata[b + NS + s];
            avail_i.fl_tag[s]   = tdata[b + 2*NS + 4 + s][5:0];
            free_tag[s]         = tdata[b + 2*NS + 4 + s][5:0];
            exp_cls[s]          = tdata[b + 3*NS + 4 + 2*s][2:0];
            exp_func[s]         = tdata[b + 3*NS + 5 + 2*s][3:0];
            decode_regs(s, tdata[b + NS + s]);
        end
        fiq_group_i.fiq_avail = tdata[b + 2*NS][1:0];
        avail_i.rob_avail     = tdata[b + 2*NS + 1][1:0];
        avail_i.rs_avail      = tdata[b + 2*NS + 2][1:0];
        avail_i.fl_avail      = tdata[b + 2*NS + 3][1:0];
        size_group(tdata[b + 2*NS], tdata[b + 2*NS + 1],
                   tdata[b + 2*NS + 2], tdata[b + 2*NS + 3]);
        rename_group();
    endtask

    task automatic check_bundle(input int g);
        compare_field(g, "dp_count_o", dp_count_o, exp_count);
        compare_field(g, "fiq_taken_o", fiq_taken_o, exp_count);
        compare_field(g, "fl_used_o", fl_used_o, exp_used);
        for (int s = 0; s < NS; s++) begin
            compare_field(g, $sformatf("slot%0d tag", s), dp_bundle_o[s].tag, exp_tag[s]);
            if (s < exp_count) begin
                compare_field(g, $sformatf("slot%0d pc", s), dp_bundle_o[s].pc,
                              tdata[g*FIELDS + s]);
                compare_field(g, $sformatf("slot%0d inst", s), dp_bundle_o[s].inst,
                              tdata[g*FIELDS + NS + s]);
                compare_field(g, $sformatf("slot%0d class", s),
                              dp_bundle_o[s].dec.fu_class, exp_cls[s]);
                compare_field(g, $sformatf("slot%0d alu func", s),
                              dp_bundle_o[s].dec.alu_func, exp_func[s]);
                compare_field(g, $sformatf("slot%0d opa sel", s),
                              dp_bundle_o[s].dec.opa_sel, exp_opa[s]);
                compare_field(g, $sformatf("slot%0d opb sel", s),
                              dp_bundle_o[s].dec.opb_sel, exp_opb[s]);
                compare_field(g, $sformatf("slot%0d rd", s), dp_bundle_o[s].dec.rd, exp_rd[s]);
                compare_field(g, $sformatf("slot%0d rs1", s), dp_bundle_o[s].dec.rs1, exp_rs1[s]);
                compare_field(g, $sformatf("slot%0d rs2", s), dp_bundle_o[s].dec.rs2, exp_rs2[s]);
                compare_field(g, $sformatf("slot%0d tag1", s), dp_bundle_o[s].tag1, exp_tag1[s]);
                compare_field(g, $sformatf("slot%0d tag2", s), dp_bundle_o[s].tag2, exp_tag2[s]);
                compare_field(g, $sformatf("slot%0d tag_old", s),
                              dp_bundle_o[s].tag_old, exp_old[s]);
            end
        end
        // Fresh table maps each register onto its own index
        if (g == 0) begin
            compare_field(g, "identity tag1", dp_bundle_o[0].tag1, exp_rs1[0]);
            compare_field(g, "identity tag2", dp_bundle_o[0].tag2, exp_rs2[0]);
        end
    endtask

    // ==================================================
    // One group through both handshakes
    // ==================================================
    task automatic run_group(input int g);
        int delay;
        grp_err = 0;
        next_drive_point();
        load_group(g);
        fiq_req_i = 1'b1;
        // Offer only after the request has been sampled
        @(negedge clk_i);
        compare_field(g, "early dp_req_o", dp_req_o, 1'b0);
        while (dp_req_o !== 1'b1) begin
            @(negedge clk_i);
        end
        compare_field(g, "fiq_ack_o before dp_ack_i", fiq_ack_o, 1'b0);
        check_bundle(g);
        held_bundle = dp_bundle_o;

        // Back-pressure with the bundle frozen
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(negedge clk_i);
            compare_field(g, "bundle held", dp_bundle_o === held_bundle, 1'b1);
            compare_field(g, "dp_req_o held", dp_req_o, 1'b1);
            compare_field(g, "fiq_ack_o while waiting", fiq_ack_o, 1'b0);
        end
        next_drive_point();
        dp_ack_i = 1'b1;
        @(negedge clk_i);
        while (fiq_ack_o !== 1'b1) begin
            @(negedge clk_i);
        end
        compare_field(g, "dp_req_o after accept", dp_req_o, 1'b0);
        commit_group();

        // Upstream releases first and ack stays up
        next_drive_point();
        fiq_req_i = 1'b0;
        @(negedge clk_i);
        compare_field(g, "fiq_ack_o with dp_ack_i high", fiq_ack_o, 1'b1);
        next_drive_point();
        dp_ack_i = 1'b0;
        @(negedge clk_i);
        while (fiq_ack_o !== 1'b0) begin
            @(negedge clk_i);
        end
        $display("Group %0d: count %0d, tags used %0d, %0d errors",
                 g, exp_count, exp_used, grp_err);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        seed        = 32'hf21b;
        checks      = 0;
        errors      = 0;
        arst_n_i    = 1'b0;
        fiq_req_i   = 1'b0;
        dp_ack_i    = 1'b0;
        fiq_group_i = '0;
        avail_i     = '0;
        $readmemh("dispatch_testdata.txt", tdata);
        reset_map_model();
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        if ($isunknown(tdata[NUM_GROUPS*FIELDS-1])) begin
            errors++;
            $display("Data file missing or holds fewer than %0d groups", NUM_GROUPS);
        end
        // Quiet handshake outputs before any request
        @(negedge clk_i);
        compare_field(-1, "dp_req_o after reset", dp_req_o, 1'b0);
        compare_field(-1, "fiq_ack_o after reset", fiq_ack_o, 1'b0);
        for (int g = 0; g < NUM_GROUPS; g++) begin
            run_group(g);
        end
        $display("Summary: %0d groups, %0d checks, %0d errors", NUM_GROUPS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Run limit sized from the group count
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- dispatch_testdata.txt
// Columns: pc0 pc1 inst0 inst1 fiq rob rs fl tag0 tag1 cls0 func0 cls1 func1
// Class and ALU function codes follow the enum order in the package
00001000 00001004 002081b3 40118233 2 2 2 2 20 21 0 0 0 1
00001008 0000100c 022082b3 0080a303 2 2 2 2 22 23 1 a 2 0
00001010 00001014 00612623 00208863 2 2 2 2 24 25 3 0 4 0
00001018 0000101c 008000ef 00008067 2 2 2 2 24 25 5 0 5 0
00001020 00001024 123453b7 00001417 2 2 2 2 25 26 0 0 0 0
00001028 0000102c 10500073 00500093 2 2 2 2 27 28 6 0 0 0
00001030 00001034 00000073 002081b3 2 2 2 2 28 29 7 0 0 0
00001038 0000103c 002081b3 300110f3 2 2 2 2 28 29 0 0 7 0
00001040 00001044 00100a13 014a0a33 1 2 2 2 29 2a 0 0 0 0
00001048 0000104c 00349493 4024d513 2 1 2 2 2a 2b 0 7 0 9
00001050 00001054 0014d593 0020a633 2 2 0 2 2b 2c 0 8 0 2
00001058 0000105c 0020b6b3 0020c733 2 2 2 1 2b 2c 0 3 0 6
00001060 00001064 00612623 0020e7b3 2 2 2 1 2c 2d 3 0 0 5
00001068 0000106c 0020f833 022098b3 2 2 2 2 2c 2d 0 4 1 b
00001070 00001074 0220a933 0220b9b3 2 2 2 2 2e 2f 1 c 1 d
00001078 0000107c 00100a13 014a0a33 2 2 2 2 30 31 0 0 0 0
00001080 00001084 00200a93 003a8a93 2 2 2 2 32 33 0 0 0 0
00001088 0000108c 023140b3 00500093 2 2 2 2 34 35 7 0 0 0
00001090 00001094 00018b03 40109093 2 2 2 2 34 35 2 0 7 0
00001098 0000109c 016180a3 fe0b1ee3 2 2 2 2 35 36 3 0 4 0
000010a0 000010a4 0020a863 ffffffff 2 2 2 2 35 36 7 0 7 0
000010a8 000010ac 002081b3 40118233 0 2 2 2 35 36 0 0 0 1
000010b0 000010b4 00500093 00000000 2 2 2 2 35 36 0 0 7 0
000010b8 000010bc 014a0a33 002081b3 2 2 2 2 36 37 0 0 0 0

//--- dispatch_stage.f
+incdir+.
dispatch_pkg.sv
inst_decoder.sv
resource_check.sv
rename_map.sv
dispatch_ctrl.sv
dispatch_stage.sv
dispatch_stage_tb.sv
